// ==== common/lq_dat_pkg.sv ====
// L1 data cache data path definitions
// Geometry, data typedefs, request formats and the byte parity function
// shared by the load pipe, the store pipe and the data array
package lq_dat_pkg;

   localparam int DC_WAYS = 4;
   localparam int DC_ROWS = 64;
   localparam int QW_BYTES = 16;
   localparam int ROW_W = 6;
   localparam int STORE_WAIT_MAX = 4;

   localparam int QW_W = QW_BYTES * 8;
   localparam int ARR_W = QW_W + QW_BYTES;
   localparam int WAIT_W = $clog2(STORE_WAIT_MAX + 1);

   typedef logic [ROW_W-1:0] row_t;
   typedef logic [$clog2(QW_BYTES)-1:0] boff_t;
   typedef logic [DC_WAYS-1:0] way_vec_t;
   typedef logic [QW_BYTES-1:0] byte_en_t;
   typedef logic [QW_W-1:0] qw_t;
   typedef logic [QW_BYTES-1:0] par_t;
   typedef logic [WAIT_W-1:0] wait_cnt_t;

   // Stored as {data, parity}; data[8*j +: 8] is covered by par[j] and enabled by byte_en[j],
   // so byte 0 of a quadword (the most significant) maps to bit 15
   typedef logic [ARR_W-1:0] arr_word_t;

   typedef enum logic [2:0] {
      SZ_BYTE  = 3'd0,
      SZ_HALF  = 3'd1,
      SZ_WORD  = 3'd2,
      SZ_DWORD = 3'd3,
      SZ_QWORD = 3'd4
   } op_size_e;

   typedef struct packed {
      row_t     row;
      boff_t    offset;
      op_size_e size;
      logic     le_mode;
      logic     algebraic;
      way_vec_t way_hit;
   } ld_req_t;

   typedef struct packed {
      row_t     row;
      way_vec_t way_en;
      byte_en_t byte_en;
      qw_t      data;
   } st_req_t;

   typedef struct packed {
      logic      rd;
      logic      wr;
      row_t      row;
      way_vec_t  way_en;
      byte_en_t  byte_en;
      arr_word_t wdata;
   } arr_cmd_t;

   // Even parity, one bit per byte
   function automatic par_t byte_parity(qw_t d);
      par_t p;
      for (int j = 0; j < QW_BYTES; j++) begin
         p[j] = ^d[8*j +: 8];
      end
      return p;
   endfunction

endpackage

// ==== rtl/ld_rotate.sv ====
// Load data formatter
// Rotates the addressed field to the low end, masks it to the operand
// size, optionally reverses byte order and sign-extends
module ld_rotate (
   input  lq_dat_pkg::qw_t      qw_in,
   input  lq_dat_pkg::boff_t    offset,
   input  lq_dat_pkg::op_size_e size,
   input  logic                 le_mode,
   input  logic                 algebraic,
   output lq_dat_pkg::qw_t      qw_out
);
   import lq_dat_pkg::*;

   logic [4:0] nbytes;
   qw_t        rot;
   qw_t        just;
   qw_t        fmt;
   logic       sign;

   assign nbytes = 5'd1 << size;

   // Byte 0 is the most significant, so the addressed byte is moved to the top
   // and the bytes ahead of it wrap around to the bottom
   assign rot = (qw_in << (8 * offset)) | (qw_in >> (QW_W - 8 * offset));

   // Field now fills the top nbytes bytes; shifting down leaves zeros above it
   assign just = rot >> (8 * (QW_BYTES - nbytes));

   always_comb begin
      fmt = '0;
      for (int i = 0; i < QW_BYTES; i++) begin
         if (i < nbytes) begin
            if (le_mode) begin
               fmt[8*i +: 8] = just[8*(nbytes - 1 - i) +: 8];
            end else begin
               fmt[8*i +: 8] = just[8*i +: 8];
            end
         end
      end
   end

   // Sign comes from the top of the field after any byte reversal
   assign sign = algebraic & fmt[8*nbytes - 1];

   always_comb begin
      qw_out = fmt;
      for (int i = 0; i < QW_BYTES; i++) begin
         if (i >= nbytes) begin
            qw_out[8*i +: 8] = {8{sign}};
         end
      end
   end

endmodule

// ==== rtl/ld_pipe.sv ====
// Load pipe
// Issues the array read at acceptance, checks the parity of every way and
// selects the hit way one cycle later, and registers the formatted result
module ld_pipe (
   input  logic                                           nclk,
   input  logic                                           rst,
   input  logic                                           ld_val,
   input  lq_dat_pkg::ld_req_t                            ld_req,
   input  logic                                           ld_ready,
   input  lq_dat_pkg::arr_word_t [lq_dat_pkg::DC_WAYS-1:0] rd_data,
   output logic                                           ld_rd_val,
   output lq_dat_pkg::row_t                               ld_rd_row,
   output logic                                           ld_data_val,
   output lq_dat_pkg::qw_t                                ld_data,
   output lq_dat_pkg::way_vec_t                           perr_way
);
   import lq_dat_pkg::*;

   logic     ld_acc;
   logic     s1_val;
   ld_req_t  s1_req;
   way_vec_t s1_perr;
   qw_t      s1_hit_data;
   qw_t      s1_fmt_data;

   assign ld_rd_val = ld_val;
   assign ld_rd_row = ld_req.row;
   assign ld_acc = ld_val & ld_ready;

   always_ff @(posedge nclk) begin
      if (rst) begin
         s1_val <= 1'b0;
      end else begin
         s1_val <= ld_acc;
      end
   end

   always_ff @(posedge nclk) begin
      if (ld_acc) begin
         s1_req <= ld_req;
      end
   end

   // Every way is checked, hit or not
   always_comb begin
      s1_hit_data = '0;
      for (int w = 0; w < DC_WAYS; w++) begin
         s1_perr[w] = (byte_parity(rd_data[w][ARR_W-1:QW_BYTES]) != rd_data[w][QW_BYTES-1:0]);
         s1_hit_data = s1_hit_data | (rd_data[w][ARR_W-1:QW_BYTES] & {QW_W{s1_req.way_hit[w]}});
      end
   end

   ld_rotate ld_rotate (
      .qw_in     (s1_hit_data),
      .offset    (s1_req.offset),
      .size      (s1_req.size),
      .le_mode   (s1_req.le_mode),
      .algebraic (s1_req.algebraic),
      .qw_out    (s1_fmt_data)
   );

   always_ff @(posedge nclk) begin
      if (rst) begin
         ld_data_val <= 1'b0;
         perr_way <= '0;
      end else begin
         ld_data_val <= s1_val;
         if (s1_val) perr_way <= s1_perr;
      end
   end

   always_ff @(posedge nclk) begin
      if (s1_val) begin
         ld_data <= s1_fmt_data;
      end
   end

   a_hit_onehot: assert property (@(posedge nclk) disable iff (rst)
      ld_acc |-> $onehot0(ld_req.way_hit))
      else $error("load way_hit has more than one way set");

endmodule

// ==== rtl/st_pipe.sv ====
// Store pipe
// Holds one accepted store, adds byte parity (inverted for injection)
// and presents it to the array until the write is granted
module st_pipe (
   input  logic                 nclk,
   input  logic                 rst,
   input  logic                 st_val,
   input  lq_dat_pkg::st_req_t  st_req,
   input  logic                 inj_parity,
   input  logic                 wr_grant,
   output logic                 st_ready,
   output logic                 wr_val,
   output lq_dat_pkg::arr_cmd_t wr_cmd
);
   import lq_dat_pkg::*;

   typedef enum logic {
      ST_EMPTY = 1'b0,
      ST_PEND  = 1'b1
   } st_state_e;

   st_state_e state;
   logic      st_acc;
   par_t      st_par;

   assign st_ready = (state == ST_EMPTY);
   assign wr_val = (state == ST_PEND);
   assign st_acc = st_val & st_ready;
   assign st_par = byte_parity(st_req.data) ^ {QW_BYTES{inj_parity}};

   always_ff @(posedge nclk) begin
      if (rst) begin
         state <= ST_EMPTY;
      end else begin
         case (state)
            ST_EMPTY: if (st_acc) state <= ST_PEND;
            ST_PEND:  if (wr_grant) state <= ST_EMPTY;
            default:  state <= ST_EMPTY;
         endcase
      end
   end

   always_ff @(posedge nclk) begin
      if (st_acc) begin
         wr_cmd.rd <= 1'b0;
         wr_cmd.wr <= 1'b1;
         wr_cmd.row <= st_req.row;
         wr_cmd.way_en <= st_req.way_en;
         wr_cmd.byte_en <= st_req.byte_en;
         wr_cmd.wdata <= {st_req.data, st_par};
      end
   end

   // A store refused while the buffer is pending is held unchanged until it is taken
   a_st_hold: assert property (@(posedge nclk) disable iff (rst)
      st_val && !st_ready |=> st_val && $stable(st_req))
      else $error("store request dropped or changed while the buffer is pending");

endmodule

// ==== dcarr/dcarr_arb.sv ====
// Data array port arbiter
// Loads win the single port unless a pending store has waited
// STORE_WAIT_MAX cycles, in which case the store is forced through
module dcarr_arb (
   input  logic                 nclk,
   input  logic                 rst,
   input  logic                 ld_rd_val,
   input  lq_dat_pkg::row_t     ld_rd_row,
   input  logic                 wr_val,
   input  lq_dat_pkg::arr_cmd_t wr_cmd,
   output logic                 ld_ready,
   output logic                 wr_grant,
   output lq_dat_pkg::arr_cmd_t arr_cmd
);
   import lq_dat_pkg::*;

   wait_cnt_t wait_cnt;
   logic      st_force;
   logic      ld_grant;

   assign st_force = (wait_cnt == WAIT_W'(STORE_WAIT_MAX));
   assign ld_ready = ~st_force;
   assign ld_grant = ld_rd_val & ~st_force;
   assign wr_grant = wr_val & ~ld_grant;

   // Counts refused cycles of the pending write
   always_ff @(posedge nclk) begin
      if (rst) begin
         wait_cnt <= '0;
      end else if (wr_grant) begin
         wait_cnt <= '0;
      end else if (wr_val && !st_force) begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   always_comb begin
      arr_cmd = wr_cmd;
      arr_cmd.rd = ld_grant;
      arr_cmd.wr = wr_grant;
      if (ld_grant) begin
         arr_cmd.row = ld_rd_row;
      end
   end

   // A pending write reaches the array once the starvation counter runs out
   a_wr_bound: assert property (@(posedge nclk) disable iff (rst)
      wr_val |-> ##[0:STORE_WAIT_MAX] wr_grant)
      else $error("pending write not granted within STORE_WAIT_MAX cycles");

endmodule

// ==== dcarr/dcarr_ways.sv ====
// Set-associative data array, one port
// Byte-enabled writes into the enabled ways, registered read of every
// way of a row, cleared by reset
module dcarr_ways (
   input  logic                                           nclk,
   input  logic                                           rst,
   input  lq_dat_pkg::arr_cmd_t                           arr_cmd,
   output lq_dat_pkg::arr_word_t [lq_dat_pkg::DC_WAYS-1:0] rd_data
);
   import lq_dat_pkg::*;

   arr_word_t mem [DC_WAYS][DC_ROWS];

   always_ff @(posedge nclk) begin
      if (rst) begin
         for (int w = 0; w < DC_WAYS; w++) begin
            for (int r = 0; r < DC_ROWS; r++) begin
               mem[w][r] <= '0;
            end
         end
      end else if (arr_cmd.wr) begin
         for (int w = 0; w < DC_WAYS; w++) begin
            for (int b = 0; b < QW_BYTES; b++) begin
               // Data byte and its parity bit move together
               if (arr_cmd.way_en[w] && arr_cmd.byte_en[b]) begin
                  mem[w][arr_cmd.row][QW_BYTES + 8*b +: 8] <=
                     arr_cmd.wdata[QW_BYTES + 8*b +: 8];
                  mem[w][arr_cmd.row][b] <= arr_cmd.wdata[b];
               end
            end
         end
      end
   end

   always_ff @(posedge nclk) begin
      if (arr_cmd.rd) begin
         for (int w = 0; w < DC_WAYS; w++) begin
            rd_data[w] <= mem[w][arr_cmd.row];
         end
      end
   end

endmodule

// ==== rtl/lq_dat_top.sv ====
// L1 data cache data path top level
// Load pipe and store pipe share the single-ported data array through
// an arbiter
module lq_dat_top (
   input  logic                 nclk,
   input  logic                 rst,
   input  logic                 ld_val,
   input  lq_dat_pkg::ld_req_t  ld_req,
   output logic                 ld_ready,
   input  logic                 st_val,
   input  lq_dat_pkg::st_req_t  st_req,
   output logic                 st_ready,
   input  logic                 inj_parity,
   output logic                 ld_data_val,
   output lq_dat_pkg::qw_t      ld_data,
   output lq_dat_pkg::way_vec_t perr_way
);
   import lq_dat_pkg::*;

   logic                        ld_rd_val;
   row_t                        ld_rd_row;
   logic                        wr_val;
   arr_cmd_t                    wr_cmd;
   logic                        wr_grant;
   arr_cmd_t                    arr_cmd;
   arr_word_t [DC_WAYS-1:0]     rd_data;

   ld_pipe ld_pipe (
      .nclk        (nclk),
      .rst         (rst),
      .ld_val      (ld_val),
      .ld_req      (ld_req),
      .ld_ready    (ld_ready),
      .rd_data     (rd_data),
      .ld_rd_val   (ld_rd_val),
      .ld_rd_row   (ld_rd_row),
      .ld_data_val (ld_data_val),
      .ld_data     (ld_data),
      .perr_way    (perr_way)
   );

   st_pipe st_pipe (
      .nclk       (nclk),
      .rst        (rst),
      .st_val     (st_val),
      .st_req     (st_req),
      .inj_parity (inj_parity),
      .wr_grant   (wr_grant),
      .st_ready   (st_ready),
      .wr_val     (wr_val),
      .wr_cmd     (wr_cmd)
   );

   dcarr_arb dcarr_arb (
      .nclk      (nclk),
      .rst       (rst),
      .ld_rd_val (ld_rd_val),
      .ld_rd_row (ld_rd_row),
      .wr_val    (wr_val),
      .wr_cmd    (wr_cmd),
      .ld_ready  (ld_ready),
      .wr_grant  (wr_grant),
      .arr_cmd   (arr_cmd)
   );

   dcarr_ways dcarr_ways (
      .nclk    (nclk),
      .rst     (rst),
      .arr_cmd (arr_cmd),
      .rd_data (rd_data)
   );

endmodule

// ==== sim/lq_dat_checker.sv ====
// Load/store data path checker
// Mirrors the data array and its injected parity, predicts every load result
// and compares it with the DUT two cycles after the load was accepted
module lq_dat_checker (
   input  logic                 nclk,
   input  logic                 rst,
   input  logic                 ld_val,
   input  lq_dat_pkg::ld_req_t  ld_req,
   input  logic                 ld_ready,
   input  logic                 st_val,
   input  lq_dat_pkg::st_req_t  st_req,
   input  logic                 st_ready,
   input  logic                 inj_parity,
   input  logic                 ld_data_val,
   input  lq_dat_pkg::qw_t      ld_data,
   input  lq_dat_pkg::way_vec_t perr_way,
   input  lq_dat_pkg::way_vec_t exp_perr,
   output int                   err_cnt,
   output int                   chk_cnt,
   output int                   pend_cnt
);
   import lq_dat_pkg::*;

   typedef struct packed {
      qw_t         data;
      way_vec_t    perr;
      way_vec_t    tbl_perr;
      logic [31:0] cyc;
   } exp_t;

   qw_t         mem_data [DC_WAYS][DC_ROWS];
   par_t        bad_par [DC_WAYS][DC_ROWS];
   exp_t        exp_q [$];
   logic [31:0] cyc;
   int          st_wait;
   logic        st_busy;

   // Field bytes count from the most significant byte and wrap at the quadword end
   function automatic qw_t format_load(qw_t d, ld_req_t r);
      int         n;
      logic [7:0] fb;
      qw_t        res;
      logic       neg;
      n = 1 << r.size;
      res = '0;
      for (int k = 0; k < n; k++) begin
         fb = d[8*(QW_BYTES - 1 - (int'(r.offset) + k) % QW_BYTES) +: 8];
         if (r.le_mode) begin
            res[8*k +: 8] = fb;
         end else begin
            res[8*(n - 1 - k) +: 8] = fb;
         end
      end
      neg = r.algebraic & res[8*n - 1];
      for (int k = n; k < QW_BYTES; k++) begin
         res[8*k +: 8] = {8{neg}};
      end
      return res;
   endfunction

   always @(posedge nclk) begin
      qw_t      hit;
      way_vec_t pv;
      exp_t     e;
      if (rst) begin
         for (int w = 0; w < DC_WAYS; w++) begin
            for (int r = 0; r < DC_ROWS; r++) begin
               mem_data[w][r] = '0;
               bad_par[w][r] = '0;
            end
         end
         exp_q.delete();
         cyc = 0;
         st_busy = 1'b0;
         st_wait = 0;
         err_cnt = 0;
         chk_cnt = 0;
         pend_cnt = 0;
      end else begin
         cyc = cyc + 1;
         if (ld_data_val) begin
            if (exp_q.size() == 0) begin
               err_cnt++;
               $display("ERROR: load result at cycle %0d with no load outstanding", cyc);
            end else begin
               e = exp_q.pop_front();
               chk_cnt++;
               if (cyc != e.cyc + 2) begin
                  err_cnt++;
                  $display("ERROR: load result at cycle %0d, due at cycle %0d", cyc, e.cyc + 2);
               end
               if (ld_data !== e.data) begin
                  err_cnt++;
                  $display("MISMATCH ld_data: got %h, expected %h", ld_data, e.data);
               end
               if (perr_way !== e.perr) begin
                  err_cnt++;
                  $display("MISMATCH perr_way: got %h, expected %h", perr_way, e.perr);
               end
               if (e.tbl_perr != e.perr) begin
                  err_cnt++;
                  $display("ERROR: test table expects parity flags %h, array model has %h",
                           e.tbl_perr, e.perr);
               end
            end
         end
         // A load reads the array before a store accepted at the same edge
         if (ld_val && ld_ready) begin
            hit = '0;
            for (int w = 0; w < DC_WAYS; w++) begin
               if (ld_req.way_hit[w]) begin
                  hit = hit | mem_data[w][ld_req.row];
               end
               pv[w] = |bad_par[w][ld_req.row];
            end
            e.data = format_load(hit, ld_req);
            e.perr = pv;
            e.tbl_perr = exp_perr;
            e.cyc = cyc;
            exp_q.push_back(e);
         end
         if (st_val && st_ready) begin
            for (int w = 0; w < DC_WAYS; w++) begin
               for (int b = 0; b < QW_BYTES; b++) begin
                  if (st_req.way_en[w] && st_req.byte_en[b]) begin
                     mem_data[w][st_req.row][8*b +: 8] = st_req.data[8*b +: 8];
                     bad_par[w][st_req.row][b] = inj_parity;
                  end
               end
            end
            st_busy = 1'b1;
            st_wait = 0;
         end else if (st_busy) begin
            if (st_ready) begin
               st_busy = 1'b0;
            end else begin
               st_wait++;
               if (st_wait == STORE_WAIT_MAX + 2) begin
                  err_cnt++;
                  $display("ERROR: store still pending after %0d cycles", st_wait);
               end
            end
         end
         pend_cnt = exp_q.size();
      end
   end

endmodule

// ==== sim/tb_lq_dat.sv ====
// Testbench for the L1 data cache data path
// Builds a table of stores, loads and idle slots and drives it into the DUT
module tb_lq_dat;
   import lq_dat_pkg::*;

   localparam int HALF = 4;

   typedef enum logic [2:0] {K_IDLE, K_LOAD, K_STORE, K_POST, K_SYNC} kind_e;

   typedef struct packed {
      kind_e    kind;
      ld_req_t  ld;
      st_req_t  st;
      logic     inj;
      way_vec_t exp_perr;
   } op_t;

   logic        nclk;
   logic        rst;
   logic        ld_val;
   ld_req_t     ld_req;
   logic        ld_ready;
   logic        st_val;
   st_req_t     st_req;
   logic        st_ready;
   logic        inj_parity;
   logic        ld_data_val;
   qw_t         ld_data;
   way_vec_t    perr_way;
   way_vec_t    exp_perr;
   int          err_cnt;
   int          chk_cnt;
   int          pend_cnt;
   int          drv_errs;
   op_t         tbl [$];
   logic [31:0] lcg_state;
   logic        tbl_done;

   always #HALF nclk = ~nclk;

   lq_dat_top UUT (.*);

   lq_dat_checker lq_dat_checker (.*);

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic qw_t rand_qw();
      return {next_rand(), next_rand(), next_rand(), next_rand()};
   endfunction

   // Random rows stay in the upper half, away from the fixed rows
   function automatic row_t rand_row();
      logic [31:0] r;
      r = next_rand();
      return row_t'(32 + r[20:16]);
   endfunction

   function automatic op_t store_op(row_t row, way_vec_t ways, byte_en_t ben, qw_t data,
                                    logic inj, logic post);
      op_t o;
      o = '0;
      o.kind = post ? K_POST : K_STORE;
      o.st.row = row;
      o.st.way_en = ways;
      o.st.byte_en = ben;
      o.st.data = data;
      o.inj = inj;
      return o;
   endfunction

   function automatic op_t load_op(row_t row, boff_t off, op_size_e size, logic le, logic alg,
                                   way_vec_t hit, way_vec_t perr);
      op_t o;
      o = '0;
      o.kind = K_LOAD;
      o.ld.row = row;
      o.ld.offset = off;
      o.ld.size = size;
      o.ld.le_mode = le;
      o.ld.algebraic = alg;
      o.ld.way_hit = hit;
      o.exp_perr = perr;
      return o;
   endfunction

   function automatic op_t ctl_op(kind_e k);
      op_t o;
      o = '0;
      o.kind = k;
      return o;
   endfunction

   task automatic build_table();
      qw_t  d1, d2, d3, d4;
      qw_t  dk;
      row_t ra, rb;
      d1 = rand_qw();
      d2 = rand_qw();
      d3 = rand_qw();
      d4 = rand_qw();
      ra = rand_row();
      rb = rand_row();
      dk = 128'h8001_7ffe_c3a5_0f10_f00d_beef_1234_5678;
      // Full store, hit and miss
      tbl.push_back(store_op(3, 4'b0100, 16'hffff, d1, 1'b0, 1'b0));
      tbl.push_back(load_op(3, 0, SZ_QWORD, 1'b0, 1'b0, 4'b0100, 4'b0000));
      tbl.push_back(load_op(3, 0, SZ_QWORD, 1'b0, 1'b0, 4'b0000, 4'b0000));
      tbl.push_back(load_op(3, 0, SZ_QWORD, 1'b0, 1'b0, 4'b0001, 4'b0000));
      // Partial store and narrow loads
      tbl.push_back(store_op(3, 4'b0100, 16'h0ff0, d2, 1'b0, 1'b0));
      tbl.push_back(load_op(3, 0, SZ_QWORD, 1'b0, 1'b0, 4'b0100, 4'b0000));
      tbl.push_back(load_op(3, 5, SZ_BYTE, 1'b0, 1'b0, 4'b0100, 4'b0000));
      tbl.push_back(load_op(3, 6, SZ_HALF, 1'b0, 1'b0, 4'b0100, 4'b0000));
      tbl.push_back(load_op(3, 4, SZ_WORD, 1'b0, 1'b0, 4'b0100, 4'b0000));
      tbl.push_back(load_op(3, 8, SZ_DWORD, 1'b0, 1'b0, 4'b0100, 4'b0000));
      tbl.push_back(load_op(3, 15, SZ_HALF, 1'b0, 1'b0, 4'b0100, 4'b0000));
      // Byte reversal and sign extension on known data
      tbl.push_back(store_op(7, 4'b0010, 16'hffff, dk, 1'b0, 1'b0));
      tbl.push_back(load_op(7, 0, SZ_BYTE, 1'b0, 1'b1, 4'b0010, 4'b0000));
      tbl.push_back(load_op(7, 2, SZ_BYTE, 1'b0, 1'b1, 4'b0010, 4'b0000));
      tbl.push_back(load_op(7, 0, SZ_HALF, 1'b1, 1'b1, 4'b0010, 4'b0000));
      tbl.push_back(load_op(7, 2, SZ_HALF, 1'b1, 1'b1, 4'b0010, 4'b0000));
      tbl.push_back(load_op(7, 4, SZ_WORD, 1'b0, 1'b1, 4'b0010, 4'b0000));
      tbl.push_back(load_op(7, 4, SZ_WORD, 1'b1, 1'b1, 4'b0010, 4'b0000));
      tbl.push_back(load_op(7, 8, SZ_DWORD, 1'b1, 1'b0, 4'b0010, 4'b0000));
      tbl.push_back(load_op(7, 8, SZ_DWORD, 1'b0, 1'b1, 4'b0010, 4'b0000));
      tbl.push_back(load_op(7, 0, SZ_QWORD, 1'b1, 1'b0, 4'b0010, 4'b0000));
      // Parity injection, partial and full clean rewrites
      tbl.push_back(store_op(9, 4'b0001, 16'hffff, d3, 1'b1, 1'b0));
      tbl.push_back(store_op(9, 4'b1000, 16'hffff, d4, 1'b0, 1'b0));
      tbl.push_back(load_op(9, 0, SZ_QWORD, 1'b0, 1'b0, 4'b1000, 4'b0001));
      tbl.push_back(load_op(9, 4, SZ_WORD, 1'b0, 1'b0, 4'b0001, 4'b0001));
      tbl.push_back(store_op(9, 4'b0001, 16'h00ff, d4, 1'b0, 1'b0));
      tbl.push_back(load_op(9, 0, SZ_QWORD, 1'b0, 1'b0, 4'b0001, 4'b0001));
      tbl.push_back(store_op(9, 4'b0001, 16'hffff, d4, 1'b0, 1'b0));
      tbl.push_back(load_op(9, 0, SZ_QWORD, 1'b0, 1'b0, 4'b0001, 4'b0000));
      tbl.push_back(store_op(10, 4'b0110, 16'h0f0f, d1, 1'b1, 1'b0));
      tbl.push_back(load_op(10, 8, SZ_DWORD, 1'b0, 1'b0, 4'b0100, 4'b0110));
      tbl.push_back(store_op(10, 4'b0110, 16'hffff, d2, 1'b0, 1'b0));
      tbl.push_back(load_op(10, 0, SZ_QWORD, 1'b0, 1'b0, 4'b0010, 4'b0000));
      // Store left pending under a stream of back-to-back loads
      tbl.push_back(store_op(ra, 4'b1111, 16'hffff, d3, 1'b0, 1'b1));
      for (int i = 0; i < 8; i++) begin
         tbl.push_back(load_op((i % 2) ? 7 : 3, boff_t'(2 * i), op_size_e'(i % 5),
                               1'(i / 4), 1'(i % 3 == 0),
                               (i % 2) ? 4'b0010 : 4'b0100, 4'b0000));
      end
      tbl.push_back(ctl_op(K_SYNC));
      tbl.push_back(load_op(ra, 0, SZ_QWORD, 1'b0, 1'b0, 4'b1000, 4'b0000));
      tbl.push_back(load_op(ra, 12, SZ_WORD, 1'b0, 1'b1, 4'b0001, 4'b0000));
      tbl.push_back(load_op(rb, 0, SZ_QWORD, 1'b0, 1'b0, 4'b0100, 4'b0000));
      tbl.push_back(ctl_op(K_IDLE));
   endtask

   // Waits for the buffered store to reach the array, then two quiet cycles
   task automatic wait_store_done();
      @(negedge nclk);
      ld_val = 1'b0;
      st_val = 1'b0;
      inj_parity = 1'b0;
      @(posedge nclk);
      while (!st_ready) @(posedge nclk);
      repeat (2) @(posedge nclk);
   endtask

   task automatic drive_op(op_t o);
      @(negedge nclk);
      ld_val = (o.kind == K_LOAD);
      ld_req = o.ld;
      exp_perr = o.exp_perr;
      st_val = (o.kind == K_STORE) || (o.kind == K_POST);
      st_req = o.st;
      inj_parity = o.inj;
      @(posedge nclk);
      while ((ld_val && !ld_ready) || (st_val && !st_ready)) @(posedge nclk);
      if (o.kind == K_STORE || o.kind == K_SYNC) begin
         wait_store_done();
      end
   endtask

   initial begin
      nclk = 1'b0;
      rst = 1'b1;
      ld_val = 1'b0;
      ld_req = '0;
      st_val = 1'b0;
      st_req = '0;
      inj_parity = 1'b0;
      exp_perr = '0;
      drv_errs = 0;
      tbl_done = 1'b0;
      lcg_state = 32'h92e99908;
      build_table();
      tbl_done = 1'b1;
      repeat (4) @(posedge nclk);
      @(negedge nclk);
      rst = 1'b0;
      foreach (tbl[i]) begin
         drive_op(tbl[i]);
      end
      repeat (4) @(negedge nclk);
      if (pend_cnt != 0) begin
         drv_errs++;
         $display("ERROR: %0d loads never returned a result", pend_cnt);
      end
      $display("errors %0d, loads checked %0d", err_cnt + drv_errs, chk_cnt);
      if (err_cnt + drv_errs == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      wait (tbl_done);
      repeat (tbl.size() * 20 + 100) @(posedge nclk);
      $display("ERROR: watchdog expired before the test table completed");
      $display("sim failed");
      $finish;
   end

endmodule

// ==== build.f ====
common/lq_dat_pkg.sv
rtl/ld_rotate.sv
rtl/ld_pipe.sv
rtl/st_pipe.sv
dcarr/dcarr_arb.sv
dcarr/dcarr_ways.sv
rtl/lq_dat_top.sv
sim/lq_dat_checker.sv
sim/tb_lq_dat.sv

// ==== Bender.yml ====
package:
  name: lq_dat

sources:
  - common/lq_dat_pkg.sv
  - rtl/ld_rotate.sv
  - rtl/ld_pipe.sv
  - rtl/st_pipe.sv
  - dcarr/dcarr_arb.sv
  - dcarr/dcarr_ways.sv
  - rtl/lq_dat_top.sv
  - target: test
    files:
      - sim/lq_dat_checker.sv
      - sim/tb_lq_dat.sv
